// ==== src/stm_macros.svh ====
// Software trace unit constants
// Marker encodings for l.nop trace instructions, the shadowed register
// index and the data and event id widths used across the design

`ifndef STM_MACROS_SVH
`define STM_MACROS_SVH

// Upper half of an l.nop instruction word
`define STM_NOP_OPCODE 16'h1500

// Immediate of the exit marker
`define STM_K_EXIT 16'h0001

// Immediate of the putchar marker
`define STM_K_PUTC 16'h0004

// Immediate bit that flags a user event
// Remaining low bits carry the event id
`define STM_K_EVENT_MSB 15

// Register that software uses for marker arguments
`define STM_SHADOW_REG 5'd3

// Core data width
`define STM_XLEN 32

// Width of the user event id
`define STM_ID_W 15

`endif

// ==== src/stm_pkg.sv ====
// Software trace unit package
// Marker classification shared by the nop decoder, the event generator
// and the checker

package stm_pkg;

  // Kind of trace marker found in a retired l.nop
  // NOP_NONE means the retire carries no marker
  // Plain instructions, zero and unknown immediates fall here
  typedef enum logic [1:0] {
    // No marker
    NOP_NONE  = 2'd0,
    // Program exit, r3 holds the exit code
    NOP_EXIT  = 2'd1,
    // Print the low byte of r3
    NOP_PUTC  = 2'd2,
    // User event, id in the immediate, value in r3
    NOP_EVENT = 2'd3
  } nop_kind_e;

endpackage

// ==== src/stm_nop_decoder.sv ====
// Trace marker decoder
// Watches the retire trace for l.nop instructions and classifies the
// immediate as exit, putchar or user event, one cycle after the retire

`timescale 1ns/1ps

`include "stm_macros.svh"

module stm_nop_decoder (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  trace_valid_i,
  input  logic [`STM_XLEN-1:0]  trace_insn_i,
  output logic                  mark_valid_o,
  output stm_pkg::nop_kind_e    mark_kind_o,
  output logic [`STM_ID_W-1:0]  mark_imm_o
);

  import stm_pkg::*;

  // Opcode and immediate halves of the instruction word
  logic [15:0] insn_op;
  logic [15:0] insn_imm;
  logic        is_nop;
  nop_kind_e   kind_d;
  logic        mark_d;

  assign insn_op  = trace_insn_i[31:16];
  assign insn_imm = trace_insn_i[15:0];

  // Only retired instructions count
  assign is_nop = trace_valid_i && (insn_op == `STM_NOP_OPCODE);

  // Immediate to marker kind
  always_comb begin
    kind_d = NOP_NONE;
    if (is_nop) begin
      if (insn_imm[`STM_K_EVENT_MSB]) begin
        // Whole upper range is user events
        kind_d = NOP_EVENT;
      end else if (insn_imm == `STM_K_EXIT) begin
        kind_d = NOP_EXIT;
      end else if (insn_imm == `STM_K_PUTC) begin
        kind_d = NOP_PUTC;
      end
      // Zero and other immediates stay NOP_NONE
    end
  end

  assign mark_d = (kind_d != NOP_NONE);

  // Marker strobe and kind
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mark_valid_o <= 1'b0;
      mark_kind_o  <= NOP_NONE;
    end else begin
      mark_valid_o <= mark_d;
      mark_kind_o  <= kind_d;
    end
  end

  // Immediate payload
  // Held between markers, only read with the strobe
  always_ff @(posedge clk_i) begin
    if (mark_d) begin
      mark_imm_o <= insn_imm[`STM_ID_W-1:0];
    end
  end

  // A registered marker always carries a real kind
  a_mark_kind_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    mark_valid_o |-> (mark_kind_o != NOP_NONE)
  );

endmodule

// ==== src/stm_arch_state.sv ====
// Architectural state shadow
// Mirrors register r3 from the write-back trace and counts
// retired instructions for event timestamps

`timescale 1ns/1ps

`include "stm_macros.svh"

module stm_arch_state (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 trace_valid_i,
  input  logic                 trace_wben_i,
  input  logic [4:0]           trace_wbreg_i,
  input  logic [`STM_XLEN-1:0] trace_wbdata_i,
  output logic [`STM_XLEN-1:0] r3_o,
  output logic [`STM_XLEN-1:0] instret_o
);

  // Write-back hits the shadowed register
  logic wb_hit;

  assign wb_hit = trace_valid_i && trace_wben_i &&
                  (trace_wbreg_i == `STM_SHADOW_REG);

  // Retire counter
  // Bubbles leave it untouched
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      instret_o <= '0;
    end else if (trace_valid_i) begin
      instret_o <= instret_o + `STM_XLEN'd1;
    end
  end

  // Shadow of r3
  // Updated in the same edge as the decoder registers a marker,
  // so a nop sees the value left by earlier retires
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      r3_o <= '0;
    end else if (wb_hit) begin
      r3_o <= trace_wbdata_i;
    end
  end

  // Write-back index must be known whenever a write is retired
  a_wbreg_known: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    (trace_valid_i && trace_wben_i) |-> !$isunknown(trace_wbreg_i)
  );

endmodule

// ==== src/stm_event_gen.sv ====
// Trace event generator
// Turns registered markers plus shadow state into putchar and user
// event strobes, and latches program termination with its exit code

`timescale 1ns/1ps

`include "stm_macros.svh"

module stm_event_gen (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 mark_valid_i,
  input  stm_pkg::nop_kind_e   mark_kind_i,
  input  logic [`STM_ID_W-1:0] mark_imm_i,
  input  logic [`STM_XLEN-1:0] r3_i,
  input  logic [`STM_XLEN-1:0] instret_i,
  output logic                 char_valid_o,
  output logic [7:0]           char_o,
  output logic                 event_valid_o,
  output logic [`STM_ID_W-1:0] event_id_o,
  output logic [`STM_XLEN-1:0] event_value_o,
  output logic [`STM_XLEN-1:0] event_count_o,
  output logic                 terminated_o,
  output logic [`STM_XLEN-1:0] exit_code_o
);

  import stm_pkg::*;

  // Marker accepted this cycle
  // Nothing gets through once the program has exited
  logic fire;
  logic fire_putc;
  logic fire_event;

  assign fire       = mark_valid_i && !terminated_o;
  assign fire_putc  = fire && (mark_kind_i == NOP_PUTC);
  assign fire_event = fire && (mark_kind_i == NOP_EVENT);

  // Strobes and termination
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      char_valid_o  <= 1'b0;
      event_valid_o <= 1'b0;
      terminated_o  <= 1'b0;
      exit_code_o   <= '0;
    end else begin
      // Single cycle pulses
      char_valid_o  <= fire_putc;
      event_valid_o <= fire_event;
      if (fire && (mark_kind_i == NOP_EXIT)) begin
        // Sticky until reset
        terminated_o <= 1'b1;
        exit_code_o  <= r3_i;
      end
    end
  end

  // Putchar payload
  // Low byte of r3 at marker time
  always_ff @(posedge clk_i) begin
    if (fire_putc) begin
      char_o <= r3_i[7:0];
    end
  end

  // User event payload
  // Count already includes the nop itself
  always_ff @(posedge clk_i) begin
    if (fire_event) begin
      event_id_o    <= mark_imm_i;
      event_value_o <= r3_i;
      event_count_o <= instret_i;
    end
  end

  // Never a char and an event in the same cycle
  a_one_strobe: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $onehot0({char_valid_o, event_valid_o})
  );

  // Silence after exit
  a_quiet_after_exit: assert property (
    @(posedge clk_i) disable iff (!rst_n_i)
    $past(terminated_o) |-> !(char_valid_o || event_valid_o)
  );

endmodule

// ==== src/stm_top.sv ====
// Software trace unit top level
// Marker decoder and state shadow watch the retire trace side by side,
// the event generator merges them into output strobes two cycles later

`timescale 1ns/1ps

`include "stm_macros.svh"

module stm_top (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 trace_valid_i,
  // Part of the retire trace, marker decode does not need it
  input  logic [`STM_XLEN-1:0] trace_pc_i,
  input  logic [`STM_XLEN-1:0] trace_insn_i,
  input  logic                 trace_wben_i,
  input  logic [4:0]           trace_wbreg_i,
  input  logic [`STM_XLEN-1:0] trace_wbdata_i,
  output logic                 char_valid_o,
  output logic [7:0]           char_o,
  output logic                 event_valid_o,
  output logic [`STM_ID_W-1:0] event_id_o,
  output logic [`STM_XLEN-1:0] event_value_o,
  output logic [`STM_XLEN-1:0] event_count_o,
  output logic                 terminated_o,
  output logic [`STM_XLEN-1:0] exit_code_o
);

  import stm_pkg::*;

  // Decoder to generator
  logic                 mark_valid;
  nop_kind_e            mark_kind;
  logic [`STM_ID_W-1:0] mark_imm;

  // Shadow to generator
  logic [`STM_XLEN-1:0] r3_value;
  logic [`STM_XLEN-1:0] instret;

  stm_nop_decoder u_decoder (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .trace_valid_i (trace_valid_i),
    .trace_insn_i  (trace_insn_i),
    .mark_valid_o  (mark_valid),
    .mark_kind_o   (mark_kind),
    .mark_imm_o    (mark_imm)
  );

  stm_arch_state u_arch_state (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .trace_valid_i  (trace_valid_i),
    .trace_wben_i   (trace_wben_i),
    .trace_wbreg_i  (trace_wbreg_i),
    .trace_wbdata_i (trace_wbdata_i),
    .r3_o           (r3_value),
    .instret_o      (instret)
  );

  stm_event_gen u_event_gen (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .mark_valid_i  (mark_valid),
    .mark_kind_i   (mark_kind),
    .mark_imm_i    (mark_imm),
    .r3_i          (r3_value),
    .instret_i     (instret),
    .char_valid_o  (char_valid_o),
    .char_o        (char_o),
    .event_valid_o (event_valid_o),
    .event_id_o    (event_id_o),
    .event_value_o (event_value_o),
    .event_count_o (event_count_o),
    .terminated_o  (terminated_o),
    .exit_code_o   (exit_code_o)
  );

endmodule

// ==== dv/stm_checker.sv ====
// Trace unit checker
// Reference model of r3, the retire count and termination, with expected
// outputs held for two cycles and compared against the DUT

`timescale 1ns/1ps

`include "stm_macros.svh"

module stm_checker (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  input  logic                 trace_valid_i,
  input  logic [`STM_XLEN-1:0] trace_insn_i,
  input  logic                 trace_wben_i,
  input  logic [4:0]           trace_wbreg_i,
  input  logic [`STM_XLEN-1:0] trace_wbdata_i,
  input  logic                 char_valid_i,
  input  logic [7:0]           char_i,
  input  logic                 event_valid_i,
  input  logic [`STM_ID_W-1:0] event_id_i,
  input  logic [`STM_XLEN-1:0] event_value_i,
  input  logic [`STM_XLEN-1:0] event_count_i,
  input  logic                 terminated_i,
  input  logic [`STM_XLEN-1:0] exit_code_i,
  output int                   error_count_o,
  output int                   check_count_o,
  output int                   char_count_o,
  output int                   event_count_o
);

  int errors = 0;
  int checks = 0;
  int chars = 0;
  int events = 0;
  int rst_cycles = 0;

  // Model state
  logic [31:0] r3_m;
  logic [31:0] count_m;
  logic        term_m;
  logic [31:0] code_m;

  // Expected outputs, index 0 is due at the current edge
  logic                 exp_char_v [0:1];
  logic [7:0]           exp_char   [0:1];
  logic                 exp_ev_v   [0:1];
  logic [`STM_ID_W-1:0] exp_ev_id  [0:1];
  logic [31:0]          exp_ev_val [0:1];
  logic [31:0]          exp_ev_cnt [0:1];
  logic                 exp_term   [0:1];
  logic [31:0]          exp_code   [0:1];

  assign error_count_o = errors;
  assign check_count_o = checks;
  assign char_count_o  = chars;
  assign event_count_o = events;

  task automatic compare_value(input string name, input logic [31:0] exp_v,
                               input logic [31:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      errors++;
      $display("FAILED %s: expected %h, actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic compare_strobe(input string name, input logic exp_v, input logic act_v);
    checks++;
    if (act_v !== exp_v) begin
      errors++;
      if (exp_v)
        $display("%s strobe missing two cycles after its marker", name);
      else
        $display("%s strobe raised with no marker two cycles before", name);
    end
  endtask

  always @(posedge clk_i) begin : model
    logic [15:0] op;
    logic [15:0] imm;
    op  = trace_insn_i[31:16];
    imm = trace_insn_i[15:0];
    if (!rst_n_i) begin
      rst_cycles++;
      // Outputs settle after the first reset edges
      if (rst_cycles > 2) begin
        compare_strobe("reset putchar", 1'b0, char_valid_i);
        compare_strobe("reset event", 1'b0, event_valid_i);
        compare_value("reset terminated", 32'd0, {31'd0, terminated_i});
        compare_value("reset exit code", 32'd0, exit_code_i);
      end
      r3_m    = '0;
      count_m = '0;
      term_m  = 1'b0;
      code_m  = '0;
      for (int i = 0; i < 2; i++) begin
        exp_char_v[i] = 1'b0;
        exp_ev_v[i]   = 1'b0;
        exp_term[i]   = 1'b0;
        exp_code[i]   = '0;
      end
    end else begin
      // Outputs visible now belong to the retire two edges back
      compare_strobe("putchar", exp_char_v[0], char_valid_i);
      if (exp_char_v[0] && char_valid_i) begin
        chars++;
        compare_value("putchar char", {24'd0, exp_char[0]}, {24'd0, char_i});
      end
      compare_strobe("event", exp_ev_v[0], event_valid_i);
      if (exp_ev_v[0] && event_valid_i) begin
        events++;
        compare_value("event id", {17'd0, exp_ev_id[0]}, {17'd0, event_id_i});
        compare_value("event value", exp_ev_val[0], event_value_i);
        compare_value("event count", exp_ev_cnt[0], event_count_i);
      end
      compare_value("terminated", {31'd0, exp_term[0]}, {31'd0, terminated_i});
      compare_value("exit code", exp_code[0], exit_code_i);

      exp_char_v[0] = exp_char_v[1];
      exp_char[0]   = exp_char[1];
      exp_ev_v[0]   = exp_ev_v[1];
      exp_ev_id[0]  = exp_ev_id[1];
      exp_ev_val[0] = exp_ev_val[1];
      exp_ev_cnt[0] = exp_ev_cnt[1];
      exp_term[0]   = exp_term[1];
      exp_code[0]   = exp_code[1];
      exp_char_v[1] = 1'b0;
      exp_ev_v[1]   = 1'b0;

      if (trace_valid_i) begin
        // Count includes the marker itself
        count_m = count_m + 32'd1;
        if (op == `STM_NOP_OPCODE && !term_m) begin
          if (imm[`STM_K_EVENT_MSB]) begin
            exp_ev_v[1]   = 1'b1;
            exp_ev_id[1]  = imm[`STM_ID_W-1:0];
            exp_ev_val[1] = r3_m;
            exp_ev_cnt[1] = count_m;
          end else if (imm == `STM_K_EXIT) begin
            term_m = 1'b1;
            code_m = r3_m;
          end else if (imm == `STM_K_PUTC) begin
            exp_char_v[1] = 1'b1;
            exp_char[1]   = r3_m[7:0];
          end
        end
        // r3 changes only after the marker has seen it
        if (trace_wben_i && trace_wbreg_i == `STM_SHADOW_REG)
          r3_m = trace_wbdata_i;
      end
      exp_term[1] = term_m;
      exp_code[1] = code_m;
    end
  end

endmodule

// ==== dv/tb_stm_top.sv ====
// Testbench for the software trace unit
// Drives a seeded random retire trace that ends in an exit marker,
// followed by more markers that must stay silent

`timescale 1ns/1ps

`include "stm_macros.svh"

module tb_stm_top;

  localparam int NUM_RETIRES  = 600;
  localparam int POST_EXIT    = 24;
  localparam int TERM_TIMEOUT = 20;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        trace_valid;
  logic [31:0] trace_pc;
  logic [31:0] trace_insn;
  logic        trace_wben;
  logic [4:0]  trace_wbreg;
  logic [31:0] trace_wbdata;

  logic                 char_valid;
  logic [7:0]           char_val;
  logic                 event_valid;
  logic [`STM_ID_W-1:0] event_id;
  logic [31:0]          event_value;
  logic [31:0]          event_count;
  logic                 terminated;
  logic [31:0]          exit_code;

  int     errors;
  int     checks;
  int     chars;
  int     events;
  int     waited;
  bit     timed_out;
  integer seed;

  always #20 clk = ~clk;

  stm_top uut (
    .clk_i (clk), .rst_n_i (rst_n),
    .trace_valid_i (trace_valid), .trace_pc_i (trace_pc), .trace_insn_i (trace_insn),
    .trace_wben_i (trace_wben), .trace_wbreg_i (trace_wbreg),
    .trace_wbdata_i (trace_wbdata),
    .char_valid_o (char_valid), .char_o (char_val),
    .event_valid_o (event_valid), .event_id_o (event_id),
    .event_value_o (event_value), .event_count_o (event_count),
    .terminated_o (terminated), .exit_code_o (exit_code)
  );

  stm_checker u_checker (
    .clk_i (clk), .rst_n_i (rst_n),
    .trace_valid_i (trace_valid), .trace_insn_i (trace_insn),
    .trace_wben_i (trace_wben), .trace_wbreg_i (trace_wbreg),
    .trace_wbdata_i (trace_wbdata),
    .char_valid_i (char_valid), .char_i (char_val),
    .event_valid_i (event_valid), .event_id_i (event_id),
    .event_value_i (event_value), .event_count_i (event_count),
    .terminated_i (terminated), .exit_code_i (exit_code),
    .error_count_o (errors), .check_count_o (checks),
    .char_count_o (chars), .event_count_o (events)
  );

  // One retire or bubble from the random mix
  task automatic drive_random_retire();
    logic [31:0] r_sel;
    logic [31:0] r_a;
    logic [31:0] r_b;
    logic        v;
    logic [31:0] insn;
    logic        wben;
    logic [4:0]  wbreg;
    logic [15:0] imm;
    r_sel = $random(seed);
    r_a   = $random(seed);
    r_b   = $random(seed);
    v     = 1'b1;
    wben  = 1'b0;
    wbreg = r_sel[9] ? `STM_SHADOW_REG : r_b[4:0];
    // Plain instruction word, never the nop opcode
    insn  = r_b;
    if (insn[31:16] == `STM_NOP_OPCODE)
      insn[31:16] = 16'h1501;
    case (r_sel[3:0])
      4'd0, 4'd1: begin
        // Bubble, possibly carrying a marker or r3 write to ignore
        v    = 1'b0;
        wben = r_sel[4];
        if (r_sel[5])
          insn = {`STM_NOP_OPCODE, r_sel[6] ? `STM_K_PUTC : 16'h8000 | r_b[15:0]};
      end
      4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7: wben = r_sel[4];
      4'd8, 4'd9: insn = {`STM_NOP_OPCODE, `STM_K_PUTC};
      4'd10, 4'd11: insn = {`STM_NOP_OPCODE, 1'b1, r_b[14:0]};
      4'd12: insn = {`STM_NOP_OPCODE, 16'h0000};
      4'd13: begin
        imm = {1'b0, r_b[14:0]};
        if (imm == 16'h0000 || imm == `STM_K_EXIT || imm == `STM_K_PUTC)
          imm = 16'h0002;
        insn = {`STM_NOP_OPCODE, imm};
      end
      default: begin
        wben  = 1'b1;
        wbreg = `STM_SHADOW_REG;
      end
    endcase
    trace_valid  <= v;
    trace_pc     <= trace_pc + 32'd4;
    trace_insn   <= insn;
    trace_wben   <= wben;
    trace_wbreg  <= wbreg;
    trace_wbdata <= r_a;
  endtask

  task automatic drive_exit();
    trace_valid <= 1'b1;
    trace_pc    <= trace_pc + 32'd4;
    trace_insn  <= {`STM_NOP_OPCODE, `STM_K_EXIT};
    trace_wben  <= 1'b0;
  endtask

  initial begin
    seed         = 32'hc30a95b2;
    timed_out    = 1'b0;
    rst_n        = 1'b0;
    trace_valid  = 1'b0;
    trace_pc     = 32'd0;
    trace_insn   = 32'd0;
    trace_wben   = 1'b0;
    trace_wbreg  = 5'd0;
    trace_wbdata = 32'd0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    for (int i = 0; i < NUM_RETIRES; i++) begin
      @(posedge clk);
      drive_random_retire();
    end
    @(posedge clk);
    drive_exit();
    // Markers keep coming while termination rises
    waited = 0;
    while (!terminated && waited < TERM_TIMEOUT) begin
      @(posedge clk);
      drive_random_retire();
      waited++;
    end
    if (!terminated) begin
      $display("timeout: terminated_o never rose after the exit marker");
      timed_out = 1'b1;
    end
    for (int i = 0; i < POST_EXIT; i++) begin
      @(posedge clk);
      drive_random_retire();
    end
    @(posedge clk);
    trace_valid <= 1'b0;
    repeat (3) @(posedge clk);
    $display("checks %0d, errors %0d, putchar strobes %0d, event strobes %0d",
             checks, errors, chars, events);
    if (chars == 0 || events == 0)
      $display("putchar or event strobes were never exercised");
    if (!timed_out && errors == 0 && chars > 0 && events > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+src
src/stm_pkg.sv
src/stm_nop_decoder.sv
src/stm_arch_state.sv
src/stm_event_gen.sv
src/stm_top.sv
dv/stm_checker.sv
dv/tb_stm_top.sv

// ==== run.sh ====
#!/bin/sh
# Build the trace unit testbench with Verilator and run it
# Succeeds only when the simulation prints the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_stm_top \
  -f filelist.f -o sim_tb || { echo "build failed"; exit 1; }

out=$(./obj_dir/sim_tb)
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1
